// ==== build.f ====
source/imu_pkg.sv
source/power_on_sequencer.sv
source/spi_master.sv
source/shtp_report_parser.sv
source/bno085_controller.sv
source/imu_spi_top.sv
testbench/tb_clock_gen.sv
testbench/bno085_model.sv
testbench/tb_imu_spi_top.sv

// ==== source/bno085_controller.sv ====
`timescale 1ns/1ns

module bno085_controller import imu_pkg::*; #(
    parameter int INT_TIMEOUT        = 3_000_000,  // Wake response limit in cycles
    parameter int REPORT_INTERVAL_US = 10_000      // Requested report period
) (
    input  logic      clk,
    input  logic      rst_n,
    output logic      tx_valid,
    output spi_byte_t tx_data,
    input  logic      tx_ready,
    input  logic      rx_valid,
    input  spi_byte_t rx_data,
    output logic      cs_n,
    output logic      ps0_wake,
    input  logic      int_n,
    output logic      pkt_start,
    output logic      byte_valid,
    output spi_byte_t byte_data,
    input  logic      hdr_valid,
    input  shtp_hdr_t hdr,
    output logic      initialized,
    output logic      error
);

    localparam int          TW       = $clog2(INT_TIMEOUT + 1);
    localparam logic [31:0] INTERVAL = REPORT_INTERVAL_US;

    ctrl_state_t   state;
    logic          pending;   // Byte handed to master, waiting for rx_valid
    logic          feature;   // 0 rotation vector, 1 gyro
    logic [7:0]    cmd_seq;   // Control channel sequence number
    logic [4:0]    byte_idx;  // Byte within command or header
    shtp_len_t     remain;    // Body bytes still to read
    logic [TW-1:0] timer;     // Wake timeout
    spi_byte_t     cmd_byte;
    logic          reading;

    assign reading    = (state == ST_READ_HDR) || (state == ST_READ_BODY);
    assign byte_valid = rx_valid && reading;  // Read bytes go to parser as is
    assign byte_data  = rx_data;
    assign tx_data    = (state == ST_SEND_CMD) ? cmd_byte : 8'h00;  // Dummy on reads
    assign tx_valid   = !pending && ((state == ST_SEND_CMD) || (state == ST_READ_BODY) ||
                                     ((state == ST_READ_HDR) && (byte_idx < 5'd4)));

    // Set Feature packet
    always_comb begin
        case (byte_idx)
            5'd0:    cmd_byte = SET_FEATURE_LEN[7:0];
            5'd1:    cmd_byte = {1'b0, SET_FEATURE_LEN[14:8]};
            5'd2:    cmd_byte = CHAN_CONTROL;
            5'd3:    cmd_byte = cmd_seq;
            5'd4:    cmd_byte = CMD_SET_FEATURE;
            5'd5:    cmd_byte = feature ? REPORT_GYRO : REPORT_ROTATION;
            5'd9:    cmd_byte = INTERVAL[7:0];  // Interval LSB first
            5'd10:   cmd_byte = INTERVAL[15:8];
            5'd11:   cmd_byte = INTERVAL[23:16];
            5'd12:   cmd_byte = INTERVAL[31:24];
            default: cmd_byte = 8'h00;  // Flags, sensitivity, batch, config
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_WAKE;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;
            pending     <= 1'b0;
            feature     <= 1'b0;
            cmd_seq     <= '0;
            byte_idx    <= '0;
            remain      <= '0;
            timer       <= '0;
            pkt_start   <= 1'b0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            pkt_start <= 1'b0;
            if (tx_valid && tx_ready) begin
                pending <= 1'b1;
            end else if (rx_valid) begin
                pending <= 1'b0;
            end
            case (state)
                ST_WAKE: begin
                    ps0_wake <= 1'b0;
                    timer    <= '0;
                    state    <= ST_WAIT_INT;
                end
                ST_WAIT_INT: begin
                    if (!int_n) begin  // Sensor awake
                        ps0_wake <= 1'b1;
                        cs_n     <= 1'b0;
                        byte_idx <= '0;
                        state    <= ST_SEND_CMD;
                    end else if (timer == TW'(INT_TIMEOUT - 1)) begin
                        error <= 1'b1;
                        state <= ST_ERROR;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                ST_SEND_CMD: begin
                    if (rx_valid) begin  // Write echo discarded
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 5'(SET_FEATURE_LEN - 1)) begin
                            cs_n  <= 1'b1;
                            state <= ST_NEXT_FEATURE;
                        end
                    end
                end
                ST_NEXT_FEATURE: begin
                    cmd_seq <= cmd_seq + 1'b1;
                    feature <= 1'b1;
                    if (feature) begin
                        initialized <= 1'b1;  // Both reports enabled
                        state       <= ST_IDLE;
                    end else begin
                        state <= ST_WAKE;
                    end
                end
                ST_IDLE: begin
                    if (!int_n) begin
                        cs_n      <= 1'b0;
                        pkt_start <= 1'b1;
                        byte_idx  <= '0;
                        state     <= ST_READ_HDR;
                    end
                end
                ST_READ_HDR: begin
                    if (rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                    end
                    if (hdr_valid) begin  // One cycle after the 4th byte
                        if (hdr.len > MAX_PACKET) begin
                            cs_n  <= 1'b1;
                            error <= 1'b1;
                            state <= ST_ERROR;
                        end else if (hdr.len <= 15'd4) begin
                            cs_n  <= 1'b1;  // Header only
                            state <= ST_DONE;
                        end else begin
                            remain <= hdr.len - 15'd4;
                            state  <= ST_READ_BODY;
                        end
                    end
                end
                ST_READ_BODY: begin
                    if (rx_valid) begin
                        remain <= remain - 1'b1;
                        if (remain == 15'd1) begin
                            cs_n  <= 1'b1;
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE:  state <= ST_IDLE;  // Gap before next INT check
                ST_ERROR: state <= ST_ERROR;
                default:  state <= ST_ERROR;
            endcase
        end
    end

    // Chip select may only rise between bytes
    a_cs_between_bytes: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cs_n) |-> (tx_ready && !pending)
    ) else $error("cs_n raised during a byte");

endmodule

// ==== source/imu_pkg.sv ====
package imu_pkg;

    typedef logic [7:0]         spi_byte_t;  // One SPI byte
    typedef logic signed [15:0] axis_t;      // Q-format sensor axis
    typedef logic [14:0]        shtp_len_t;  // Packet length without continuation bit

    // SHTP header as seen on the wire, continuation bit dropped
    typedef struct packed {
        shtp_len_t len;
        logic [7:0] chan;
        logic [7:0] seq;
    } shtp_hdr_t;

    typedef struct packed {
        axis_t w;
        axis_t x;
        axis_t y;
        axis_t z;
    } quat_t;

    typedef struct packed {
        axis_t x;
        axis_t y;
        axis_t z;
    } gyro_t;

    typedef enum logic [3:0] {
        ST_WAKE,          // Pull PS0/WAKE low
        ST_WAIT_INT,      // Wait for sensor to answer the wake
        ST_SEND_CMD,      // Shift out one Set Feature packet
        ST_NEXT_FEATURE,  // Pick next report or finish setup
        ST_IDLE,          // Wait for INT
        ST_READ_HDR,      // Clock in the 4 header bytes
        ST_READ_BODY,     // Clock in length - 4 bytes
        ST_DONE,
        ST_ERROR
    } ctrl_state_t;

    localparam logic [7:0] CHAN_CONTROL    = 8'd2;
    localparam logic [7:0] CHAN_REPORTS    = 8'd3;
    localparam spi_byte_t  REPORT_ROTATION = 8'h05;
    localparam spi_byte_t  REPORT_GYRO     = 8'h02;
    localparam spi_byte_t  CMD_SET_FEATURE = 8'hFD;
    localparam spi_byte_t  TIMESTAMP_BASE  = 8'hFB;
    localparam shtp_len_t  SET_FEATURE_LEN = 15'd21;  // Header included
    localparam shtp_len_t  MAX_PACKET      = 15'd64;

endpackage

// ==== source/imu_spi_top.sv ====
`timescale 1ns/1ns

module imu_spi_top import imu_pkg::*; #(
    parameter int SENSOR_RST_CYCLES  = 300_000,
    parameter int CTRL_RST_CYCLES    = 6_000_000,
    parameter int CLK_DIV            = 2,
    parameter int INT_TIMEOUT        = 3_000_000,
    parameter int REPORT_INTERVAL_US = 10_000,
    parameter int HEARTBEAT_BIT      = 21  // About 0.7 s per toggle at 3 MHz
) (
    input  logic  clk,
    input  logic  fpga_rst_n,
    output logic  sclk,
    output logic  mosi,
    input  logic  miso,
    output logic  cs_n,
    output logic  ps0_wake,
    output logic  sensor_rst_n,
    input  logic  int_n,
    output logic  quat_valid,
    output quat_t quat,
    output logic  gyro_valid,
    output gyro_t gyro,
    output logic  led_initialized,
    output logic  led_error,
    output logic  led_heartbeat
);

    logic      ctrl_rst_n;  // Reset for everything past the sequencer
    logic      tx_valid;
    logic      tx_ready;
    logic      rx_valid;
    spi_byte_t tx_data;
    spi_byte_t rx_data;
    logic      pkt_start;
    logic      byte_valid;
    spi_byte_t byte_data;
    logic      hdr_valid;
    shtp_hdr_t hdr;

    logic [HEARTBEAT_BIT:0] hb_cnt;

    power_on_sequencer #(
        .SENSOR_RST_CYCLES(SENSOR_RST_CYCLES),
        .CTRL_RST_CYCLES  (CTRL_RST_CYCLES)
    ) u_seq (
        .clk(clk), .fpga_rst_n(fpga_rst_n),
        .sensor_rst_n(sensor_rst_n), .ctrl_rst_n(ctrl_rst_n)
    );

    spi_master #(.CLK_DIV(CLK_DIV)) u_spi (
        .clk(clk), .rst_n(ctrl_rst_n),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
        .rx_valid(rx_valid), .rx_data(rx_data),
        .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    bno085_controller #(
        .INT_TIMEOUT       (INT_TIMEOUT),
        .REPORT_INTERVAL_US(REPORT_INTERVAL_US)
    ) u_ctrl (
        .clk(clk), .rst_n(ctrl_rst_n),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
        .rx_valid(rx_valid), .rx_data(rx_data),
        .cs_n(cs_n), .ps0_wake(ps0_wake), .int_n(int_n),
        .pkt_start(pkt_start), .byte_valid(byte_valid), .byte_data(byte_data),
        .hdr_valid(hdr_valid), .hdr(hdr),
        .initialized(led_initialized), .error(led_error)
    );

    shtp_report_parser u_parse (
        .clk(clk), .rst_n(ctrl_rst_n),
        .pkt_start(pkt_start), .byte_valid(byte_valid), .byte_data(byte_data),
        .hdr_valid(hdr_valid), .hdr(hdr),
        .quat_valid(quat_valid), .quat(quat),
        .gyro_valid(gyro_valid), .gyro(gyro)
    );

    // Heartbeat starts with the controller, shows the clock and reset are alive
    always_ff @(posedge clk or negedge ctrl_rst_n) begin
        if (!ctrl_rst_n) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign led_heartbeat = hb_cnt[HEARTBEAT_BIT];

endmodule

// ==== source/power_on_sequencer.sv ====
`timescale 1ns/1ns

module power_on_sequencer #(
    parameter int SENSOR_RST_CYCLES = 300_000,   // About 100 ms at 3 MHz
    parameter int CTRL_RST_CYCLES   = 6_000_000  // Must be above SENSOR_RST_CYCLES
) (
    input  logic clk,
    input  logic fpga_rst_n,
    output logic sensor_rst_n,
    output logic ctrl_rst_n
);

    localparam int CW = $clog2(CTRL_RST_CYCLES + 1);

    logic [CW-1:0] cnt;  // Cycles since FPGA reset release, saturating

    always_ff @(posedge clk or negedge fpga_rst_n) begin
        if (!fpga_rst_n) begin
            cnt          <= '0;
            sensor_rst_n <= 1'b0;  // Sensor held in reset
            ctrl_rst_n   <= 1'b0;  // Controller held in reset
        end else begin
            if (cnt < CTRL_RST_CYCLES) begin
                cnt <= cnt + 1'b1;
            end
            // Registered compares, so each release lands one edge after the count
            sensor_rst_n <= (cnt >= SENSOR_RST_CYCLES);
            ctrl_rst_n   <= (cnt >= CTRL_RST_CYCLES);
        end
    end

    // Controller must never run while the sensor is still in reset
    a_ctrl_after_sensor: assert property (
        @(posedge clk) disable iff (!fpga_rst_n)
        ctrl_rst_n |-> sensor_rst_n
    ) else $error("controller released before sensor");

endmodule

// ==== source/shtp_report_parser.sv ====
`timescale 1ns/1ns

module shtp_report_parser import imu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pkt_start,
    input  logic      byte_valid,
    input  spi_byte_t byte_data,
    output logic      hdr_valid,
    output shtp_hdr_t hdr,
    output logic      quat_valid,
    output quat_t     quat,
    output logic      gyro_valid,
    output gyro_t     gyro
);

    logic [6:0] idx;     // Byte index within packet, saturating
    logic       ts_ok;   // Timestamp marker seen at byte 4
    spi_byte_t  rep_id;  // Report ID from byte 9
    spi_byte_t  lo_byte; // Low half of the axis being assembled
    axis_t      ax0;
    axis_t      ax1;
    axis_t      ax2;
    logic       rpt_ok;  // Report channel with timestamp marker

    assign rpt_ok = (hdr.chan == CHAN_REPORTS) && ts_ok;

    // Byte index and valid strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx        <= '0;
            hdr_valid  <= 1'b0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            hdr_valid  <= 1'b0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            if (pkt_start) begin
                idx <= '0;
            end else if (byte_valid) begin
                if (idx != '1) begin
                    idx <= idx + 1'b1;
                end
                hdr_valid <= (idx == 7'd3);  // Header complete after 4th byte
                // Gyro ends at z high byte, rotation at real high byte
                gyro_valid <= (idx == 7'd18) && rpt_ok && (rep_id == REPORT_GYRO);
                quat_valid <= (idx == 7'd20) && rpt_ok && (rep_id == REPORT_ROTATION);
            end
        end
    end

    // Field capture, little-endian axes
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (idx)
                7'd0: hdr.len[7:0]  <= byte_data;
                7'd1: hdr.len[14:8] <= byte_data[6:0];  // Drop continuation bit
                7'd2: hdr.chan      <= byte_data;
                7'd3: hdr.seq       <= byte_data;
                7'd4: ts_ok         <= (byte_data == TIMESTAMP_BASE);
                7'd9: rep_id        <= byte_data;
                7'd13, 7'd15, 7'd17, 7'd19: lo_byte <= byte_data;
                7'd14: ax0 <= {byte_data, lo_byte};  // i or x
                7'd16: ax1 <= {byte_data, lo_byte};  // j or y
                7'd18: begin
                    ax2  <= {byte_data, lo_byte};    // k or z
                    gyro <= '{x: ax0, y: ax1, z: {byte_data, lo_byte}};
                end
                7'd20: begin
                    // Real part is the 4th axis and maps to w
                    quat <= '{w: {byte_data, lo_byte}, x: ax0, y: ax1, z: ax2};
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== source/spi_master.sv ====
`timescale 1ns/1ns

module spi_master import imu_pkg::*; #(
    parameter int CLK_DIV = 2  // clk cycles per SCLK half period
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tx_valid,
    input  spi_byte_t tx_data,
    output logic      tx_ready,
    output logic      rx_valid,
    output spi_byte_t rx_data,
    output logic      sclk,
    output logic      mosi,
    input  logic      miso
);

    localparam int DW = $clog2(CLK_DIV + 1);

    logic          busy;     // Byte in flight
    logic [DW-1:0] div_cnt;  // Half period divider
    logic [2:0]    bit_cnt;  // Rising edges seen so far
    logic          tick;     // SCLK toggles this cycle
    spi_byte_t     shreg;    // Out on MSB, in on LSB

    assign tick     = busy && (div_cnt == DW'(CLK_DIV - 1));
    assign tx_ready = !busy;
    assign rx_data  = shreg;  // Holds received byte once rx_valid pulses

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            sclk     <= 1'b1;  // Mode 3 idle high
            mosi     <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (tx_valid) begin  // Accept byte
                    busy    <= 1'b1;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (tick) begin
                div_cnt <= '0;
                sclk    <= !sclk;
                if (sclk) begin
                    mosi <= shreg[7];  // Falling edge, present next bit
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;  // Rising edge, miso sampled below
                    if (bit_cnt == 3'd7) begin
                        busy     <= 1'b0;  // Last rising edge ends the byte
                        rx_valid <= 1'b1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Shift register, payload only
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            shreg <= tx_data;
        end else if (tick && !sclk) begin
            shreg <= {shreg[6:0], miso};  // Sample on SCLK rise
        end
    end

    // No queue here, the controller must hold off until the byte completes
    a_no_offer_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        !tx_ready |-> !tx_valid
    ) else $error("byte offered during active shift");

    // Every accepted byte returns 16 x CLK_DIV cycles after the accepting edge
    a_byte_time: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_valid && tx_ready) |=> ##(16 * CLK_DIV) rx_valid
    ) else $error("byte timing off");

endmodule

// ==== testbench/bno085_model.sv ====
`timescale 1ns/1ns

module bno085_model import imu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    answer_wake,  // 0 models a sensor that stays asleep
    input  logic                    pkt_go,       // Announce pkt_image on INT
    input  logic [MAX_PACKET*8-1:0] pkt_image,    // Byte i at [i*8 +: 8]
    input  logic [6:0]              pkt_len,
    input  logic                    sclk,
    input  logic                    mosi,
    input  logic                    cs_n,
    input  logic                    ps0_wake,
    output logic                    miso = 1'b1,
    output logic                    int_n = 1'b1,
    output logic [3:0]              wake_count,
    output logic [3:0]              cmd_count,
    output logic [6:0]              last_count,   // Bytes in the last transfer
    output logic [2*32*8-1:0]       cmd_log       // Command n byte j at [(n*32+j)*8 +: 8]
);

    logic                    sclk_q;
    logic                    cs_q;
    logic [9:0]              bit_cnt;  // Bits since cs_n fell
    logic [7:0]              rx_sr;
    logic [MAX_PACKET*8-1:0] img;      // Packet being read out
    logic [6:0]              img_len;
    logic                    armed;    // Transfer follows a wake answer
    logic                    waking;
    logic [2:0]              wake_wait;

    // Bit that goes out at position n, zero past the packet end
    function automatic logic out_bit(input logic [9:0] n);
        if (n[9:3] >= img_len) begin
            return 1'b0;
        end
        return img[n[9:3] * 8 + (7 - n[2:0])];  // MSB first
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q     <= 1'b1;
            cs_q       <= 1'b1;
            bit_cnt    <= '0;
            rx_sr      <= '0;
            img        <= '0;
            img_len    <= '0;
            armed      <= 1'b0;
            waking     <= 1'b0;
            wake_wait  <= '0;
            miso       <= 1'b1;
            int_n      <= 1'b1;
            wake_count <= '0;
            cmd_count  <= '0;
            last_count <= '0;
            cmd_log    <= '0;
        end else begin
            sclk_q <= sclk;
            cs_q   <= cs_n;
            // Wake answer a few cycles after PS0 falls
            if (answer_wake && !ps0_wake && cs_n && int_n && !waking) begin
                waking    <= 1'b1;
                wake_wait <= '0;
            end else if (waking) begin
                if (wake_wait == 3'd3) begin
                    int_n      <= 1'b0;
                    armed      <= 1'b1;
                    waking     <= 1'b0;
                    wake_count <= wake_count + 1'b1;
                end else begin
                    wake_wait <= wake_wait + 1'b1;
                end
            end
            if (pkt_go) begin  // Data ready
                int_n   <= 1'b0;
                img     <= pkt_image;
                img_len <= pkt_len;
            end
            if (cs_n) begin
                bit_cnt <= '0;
            end else begin
                int_n <= 1'b1;  // Host has selected us
                if (sclk_q && !sclk) begin
                    miso <= out_bit(bit_cnt);  // Falling edge, next bit out
                end
                if (!sclk_q && sclk) begin
                    rx_sr   <= {rx_sr[6:0], mosi};  // Rising edge, sample
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt[2:0] == 3'd7 && armed && bit_cnt[9:3] < 32) begin
                        cmd_log[(cmd_count * 32 + bit_cnt[9:3]) * 8 +: 8] <= {rx_sr[6:0], mosi};
                    end
                end
            end
            if (!cs_q && cs_n) begin  // End of transfer
                last_count <= bit_cnt[9:3];
                if (armed) begin
                    cmd_count <= cmd_count + 1'b1;
                    armed     <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD     = 40,  // ns
    parameter int RST_CYCLES = 4
) (
    input  logic restart,          // Pulse to run the reset again
    output logic clk = 1'b0,
    output logic rst_n = 1'b0
);

    int rst_cnt = 0;

    always #(PERIOD / 2) clk = !clk;

    always @(posedge clk) begin
        if (restart) begin
            rst_n   <= 1'b0;
            rst_cnt <= 0;
        end else if (!rst_n) begin
            if (rst_cnt == RST_CYCLES - 1) begin
                rst_n <= 1'b1;  // Released on the 4th edge
            end else begin
                rst_cnt <= rst_cnt + 1;
            end
        end
    end

endmodule

// ==== testbench/tb_imu_spi_top.sv ====
`timescale 1ns/1ns

module tb_imu_spi_top import imu_pkg::*;;

    localparam int SENSOR_RST  = 20;
    localparam int CTRL_RST    = 60;
    localparam int CLK_DIV     = 2;
    localparam int INT_TIMEOUT = 200;
    localparam int INTERVAL_US = 1000;
    localparam int HB_BIT      = 4;
    localparam int NUM_PKTS    = 24;
    localparam int PKT_CYCLES  = 64 * 16 * CLK_DIV + 64;  // Longest read plus slack
    localparam longint WATCHDOG_CYCLES =
        (NUM_PKTS + 4) * PKT_CYCLES + 2 * (CTRL_RST + INT_TIMEOUT) + 200;

    logic                    clk;
    logic                    fpga_rst_n;
    logic                    restart;
    logic                    sclk, mosi, miso, cs_n, ps0_wake, sensor_rst_n, int_n;
    logic                    quat_valid, gyro_valid;
    quat_t                   quat;
    gyro_t                   gyro;
    logic                    led_initialized, led_error, led_heartbeat;
    logic                    answer_wake, pkt_go;
    logic [MAX_PACKET*8-1:0] pkt_image;
    logic [6:0]              pkt_len;
    logic [3:0]              wake_count, cmd_count;
    logic [6:0]              last_count;
    logic [2*32*8-1:0]       cmd_log;

    logic [31:0] lfsr = 32'hdbac_f438;
    int          err_count = 0;
    logic        exp_kind[$];  // 1 for gyro
    logic [63:0] exp_data[$];

    tb_clock_gen u_clk (.restart(restart), .clk(clk), .rst_n(fpga_rst_n));

    bno085_model u_sensor (
        .clk(clk), .rst_n(fpga_rst_n), .answer_wake(answer_wake), .pkt_go(pkt_go),
        .pkt_image(pkt_image), .pkt_len(pkt_len), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
        .ps0_wake(ps0_wake), .miso(miso), .int_n(int_n), .wake_count(wake_count),
        .cmd_count(cmd_count), .last_count(last_count), .cmd_log(cmd_log)
    );

    imu_spi_top #(
        .SENSOR_RST_CYCLES(SENSOR_RST), .CTRL_RST_CYCLES(CTRL_RST), .CLK_DIV(CLK_DIV),
        .INT_TIMEOUT(INT_TIMEOUT), .REPORT_INTERVAL_US(INTERVAL_US), .HEARTBEAT_BIT(HB_BIT)
    ) uut (
        .clk(clk), .fpga_rst_n(fpga_rst_n), .sclk(sclk), .mosi(mosi), .miso(miso),
        .cs_n(cs_n), .ps0_wake(ps0_wake), .sensor_rst_n(sensor_rst_n), .int_n(int_n),
        .quat_valid(quat_valid), .quat(quat), .gyro_valid(gyro_valid), .gyro(gyro),
        .led_initialized(led_initialized), .led_error(led_error),
        .led_heartbeat(led_heartbeat)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        err_count++;
        $display("Error at %0t ns: %s", $time, why);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    // Expected Set Feature byte j of command n
    function automatic logic [7:0] cmd_expect(input int n, input int j);
        logic [31:0] iv;
        iv = INTERVAL_US;
        case (j)
            0:       return 8'd21;
            2:       return 8'd2;   // Control channel
            3:       return 8'(n);  // Sequence per command
            4:       return 8'hFD;
            5:       return (n == 0) ? 8'h05 : 8'h02;
            9:       return iv[7:0];
            10:      return iv[15:8];
            11:      return iv[23:16];
            12:      return iv[31:24];
            default: return 8'h00;
        endcase
    endfunction

    task automatic put_byte(input int i, input logic [7:0] b);
        pkt_image[i*8 +: 8] = b;
    endtask

    // Announce the packet and wait for the full read
    task automatic transfer_packet();
        int n;
        @(posedge clk);
        pkt_go <= 1'b1;
        @(posedge clk);
        pkt_go <= 1'b0;
        n = 0;
        while (cs_n) begin
            @(negedge clk);
            n++;
            if (n > PKT_CYCLES) fail_run("INT was raised but cs_n never fell");
        end
        n = 0;
        while (!cs_n) begin
            @(negedge clk);
            n++;
            if (n > PKT_CYCLES) fail_run("read never ended, cs_n stuck low");
        end
        repeat (4) @(negedge clk);  // Let the last sample pulse through
    endtask

    // Kind 0-2 rotation, 3-5 gyro, 6 control channel, 7 unknown report ID
    task automatic send_report(input int kind);
        logic [15:0] ax [4];
        logic [7:0]  id;
        logic [7:0]  chan;
        int          len;
        chan      = 8'd3;
        id        = 8'h05;
        len       = 23;  // Header, timestamp, 4 fields, 4 axes, accuracy
        pkt_image = '0;
        for (int i = 0; i < 4; i++) ax[i] = rand_bits(16);
        if (kind >= 3 && kind <= 5) begin
            id  = 8'h02;
            len = 19;
        end else if (kind == 6) begin
            chan = 8'd2;
        end else if (kind == 7) begin
            id  = 8'h10 | rand_bits(4);  // Never 02 or 05
            len = 19;
        end
        put_byte(0, len);
        put_byte(1, 8'h00);
        put_byte(2, chan);
        put_byte(3, rand_bits(8));
        put_byte(4, 8'hFB);
        for (int i = 5; i < 9; i++) put_byte(i, rand_bits(8));
        put_byte(9, id);
        for (int i = 10; i < 13; i++) put_byte(i, rand_bits(8));
        for (int i = 0; i < 4; i++) begin
            put_byte(13 + 2 * i, ax[i][7:0]);  // Little endian
            put_byte(14 + 2 * i, ax[i][15:8]);
        end
        put_byte(21, rand_bits(8));
        put_byte(22, rand_bits(8));
        if (kind <= 2) begin
            exp_kind.push_back(1'b0);
            exp_data.push_back({ax[3], ax[0], ax[1], ax[2]});  // Real part is w
        end else if (kind <= 5) begin
            exp_kind.push_back(1'b1);
            exp_data.push_back({16'h0, ax[0], ax[1], ax[2]});
        end
        pkt_len = len;
        transfer_packet();
    endtask

    // Sample monitor against the queued reference
    always @(negedge clk) begin
        if (quat_valid && gyro_valid) begin
            fail_run("quat and gyro pulsed in the same cycle");
        end else if (quat_valid || gyro_valid) begin
            if (exp_kind.size() == 0) begin
                fail_run("sample pulse with no report sent");
            end else begin
                check("gyro_valid", gyro_valid, exp_kind[0]);
                check(gyro_valid ? "gyro" : "quat", gyro_valid ? 64'(gyro) : quat, exp_data[0]);
                void'(exp_kind.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("Watchdog expired at %0t ns, the run did not finish", $time);
        $display("** FAIL **");
        $fatal(1, "watchdog");
    end

    initial begin
        int cycles;
        restart     = 1'b0;
        answer_wake = 1'b1;
        pkt_go      = 1'b0;
        pkt_image   = '0;
        pkt_len     = '0;
        // Reset staging, edge 0 is the release edge
        @(posedge fpga_rst_n);
        @(negedge clk);
        check("sensor_rst_n", sensor_rst_n, 0);
        for (int k = 1; k <= 140; k++) begin
            @(negedge clk);
            check("sensor_rst_n", sensor_rst_n, k >= SENSOR_RST + 1);
            check("led_heartbeat", led_heartbeat,
                  (k >= CTRL_RST + 1) ? (((k - CTRL_RST - 1) >> HB_BIT) & 1) : 0);
        end
        // Configuration
        cycles = 0;
        while (!led_initialized) begin
            @(negedge clk);
            cycles++;
            if (cycles > 4 * PKT_CYCLES) fail_run("led_initialized never rose");
        end
        check("wake_count", wake_count, 2);
        check("cmd_count", cmd_count, 2);
        for (int n = 0; n < 2; n++) begin
            for (int j = 0; j < 21; j++) begin
                check($sformatf("command %0d byte %0d", n, j),
                      cmd_log[(n * 32 + j) * 8 +: 8], cmd_expect(n, j));
            end
        end
        // Reports, one of each kind first
        for (int p = 0; p < NUM_PKTS; p++) begin
            send_report((p < 8) ? p : rand_bits(3));
            check("samples still expected", exp_kind.size(), 0);
        end
        check("led_error", led_error, 0);
        // Oversized header
        pkt_image = '0;
        put_byte(0, 8'd80);
        put_byte(2, 8'd3);
        pkt_len = 7'd4;
        transfer_packet();
        check("led_error", led_error, 1);
        check("bytes read of oversized packet", last_count, 4);
        // Error state ignores a new INT, so no further read starts
        @(posedge clk);
        pkt_go <= 1'b1;
        @(posedge clk);
        pkt_go <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            check("cs_n", cs_n, 1);
        end
        // Second run, sensor never answers the wake
        @(posedge clk);
        answer_wake <= 1'b0;
        restart     <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        @(posedge fpga_rst_n);
        cycles = 0;
        while (ps0_wake !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 4 * CTRL_RST) fail_run("ps0_wake never fell after reset");
        end
        cycles = 0;
        while (!led_error) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * INT_TIMEOUT) fail_run("led_error never rose on wake timeout");
        end
        check("wake timeout cycles", cycles, INT_TIMEOUT);
        check("led_initialized", led_initialized, 0);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
